/* Makefile */
VERILATOR  = verilator
TOP        = tb_traffic_gen_top
FILELIST   = traffic_gen_top.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --assert -Wno-fatal -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

/* design/axi_pkg.sv */
package axi_pkg;

	localparam int axi_addr_bits = 32;
	localparam int axi_data_bits = 64;

	typedef struct packed {
		logic [axi_addr_bits-1:0] addr;
		logic [7:0]               len;  // Beats minus one
	} axi_aw_t;

	typedef struct packed {
		logic [axi_data_bits-1:0]   data;
		logic [axi_data_bits/8-1:0] strb;
		logic                       last;
	} axi_w_t;

	typedef logic [1:0] axi_resp_t;

	typedef enum logic [1:0] {
		wr_idle,
		wr_addr,
		wr_data,
		wr_resp
	} wr_state_t;

	// Word written ahead of each burst
	localparam logic [axi_data_bits-1:0] sum_marker = 64'h0000_0000_0006_B975;

endpackage

/* design/axi_write_master.sv */
`timescale 1ns/1ps

module axi_write_master #(
	parameter logic [axi_pkg::axi_addr_bits-1:0] base_addr  = 32'h1000_0000,
	parameter logic [axi_pkg::axi_addr_bits-1:0] sum_offset = 32'h0000_1000,
	parameter int                                burst_len  = 32
) (
	input  logic               sys_clk,
	input  logic               sys_rst,
	output logic               aw_valid,
	output axi_pkg::axi_aw_t   aw,
	input  logic               aw_ready,
	output logic               w_valid,
	output axi_pkg::axi_w_t    w,
	input  logic               w_ready,
	input  logic               b_valid,
	input  axi_pkg::axi_resp_t b_resp,
	output logic               b_ready
);

	axi_pkg::wr_state_t state;
	axi_pkg::wr_state_t state_next;
	logic               is_marker;  // Current transaction is the marker write
	logic [7:0]         beat_cnt;

	assign aw_valid = (state == axi_pkg::wr_addr);
	assign w_valid  = (state == axi_pkg::wr_data);
	assign b_ready  = (state == axi_pkg::wr_resp);

	//////////////////////////////////////////////////////////////////////
	// Write FSM

	always_comb begin
		state_next = state;
		case (state)
			axi_pkg::wr_idle: state_next = axi_pkg::wr_addr;
			axi_pkg::wr_addr: if (aw_ready) state_next = axi_pkg::wr_data;
			axi_pkg::wr_data: if (w_ready && w.last) state_next = axi_pkg::wr_resp;
			axi_pkg::wr_resp: if (b_valid) state_next = axi_pkg::wr_idle; // Response code not checked
			default: state_next = axi_pkg::wr_idle;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= axi_pkg::wr_idle;
			is_marker <= 1'b0;
			beat_cnt  <= '0;
		end else begin
			state <= state_next;
			if (state == axi_pkg::wr_idle)
				is_marker <= !is_marker;
			if (state != axi_pkg::wr_data)
				beat_cnt <= '0;
			else if (w_ready)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and data payload

	// Set up while leaving idle, so select on the flag value about to be taken
	always_ff @(posedge sys_clk) begin
		if (state == axi_pkg::wr_idle) begin
			if (is_marker) begin
				aw.addr <= base_addr + sum_offset;
				aw.len  <= 8'(burst_len - 1);
			end else begin
				aw.addr <= base_addr;
				aw.len  <= 8'd0;
			end
		end
	end

	always_comb begin
		if (is_marker)
			w.data = axi_pkg::sum_marker;
		else
			w.data = {{(axi_pkg::axi_data_bits - 8){1'b0}}, beat_cnt}; // Beat index
		w.strb = '1;
		w.last = (beat_cnt == aw.len);
	end

endmodule

/* design/byte_streamer.sv */
`timescale 1ns/1ps

module byte_streamer #(
	parameter int frame_gap = 16
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  load,
	input  pkt_pkg::frame_req_t   req,
	output logic                  done,
	output logic                  rx_valid,
	output pkt_pkg::stream_beat_t rx_beat,
	input  logic                  rx_ready
);

	localparam int gap_bits = $clog2(frame_gap + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_send,
		st_gap
	} stream_state_t;

	stream_state_t         state;
	pkt_pkg::frame_image_t shift_q;
	pkt_pkg::frame_len_t   byte_cnt;  // Bytes still to go
	logic [gap_bits-1:0]   gap_cnt;
	logic                  xfer;

	assign rx_valid = (state == st_send);
	assign xfer     = rx_valid && rx_ready;

	always_comb begin
		rx_beat.data = shift_q[pkt_pkg::frame_bits-1 -: 8];
		rx_beat.last = (byte_cnt == 7'd1);
	end

	always_ff @(posedge sys_clk) begin
		if (load)
			shift_q <= req.image;
		else if (xfer)
			shift_q <= shift_q << 8; // Next byte to the top
	end

	//////////////////////////////////////////////////////////////////////
	// Frame and gap sequencing

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= st_idle;
			byte_cnt <= '0;
			gap_cnt  <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (load) begin
				byte_cnt <= req.len;
				state    <= st_send;
			end else begin
				case (state)
					st_send: if (xfer) begin
						byte_cnt <= byte_cnt - 1'b1;
						if (byte_cnt == 7'd1) begin
							state   <= st_gap;
							gap_cnt <= gap_bits'(frame_gap - 1);
						end
					end
					st_gap: if (gap_cnt == '0) begin
						done  <= 1'b1;
						state <= st_idle;
					end else begin
						gap_cnt <= gap_cnt - 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* design/frame_rotator.sv */
`timescale 1ns/1ps

module frame_rotator #(
	parameter int frames_per_kind = 5
) (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                done,
	output logic                load,
	output pkt_pkg::frame_req_t req
);

	localparam int cnt_bits = $clog2(frames_per_kind + 1);

	pkt_pkg::frame_kind_t kind;
	pkt_pkg::frame_kind_t kind_next;
	logic [cnt_bits-1:0]  frame_cnt;
	logic                 first;  // First load after reset

	always_comb begin
		case (kind)
			pkt_pkg::kind_arp: begin
				req.image = pkt_pkg::arp_image;
				req.len   = pkt_pkg::arp_len;
				kind_next = pkt_pkg::kind_icmp;
			end
			pkt_pkg::kind_icmp: begin
				req.image = pkt_pkg::icmp_image;
				req.len   = pkt_pkg::icmp_len;
				kind_next = pkt_pkg::kind_udp;
			end
			default: begin
				req.image = pkt_pkg::udp_image;
				req.len   = pkt_pkg::udp_len;
				kind_next = pkt_pkg::kind_arp;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			load      <= 1'b0;
			first     <= 1'b1;
			kind      <= pkt_pkg::kind_udp;
			frame_cnt <= '0;
		end else begin
			load  <= first | done;
			first <= 1'b0;
			if (load) begin // Count the frame just handed over
				if (frame_cnt == cnt_bits'(frames_per_kind - 1)) begin
					frame_cnt <= '0;
					kind      <= kind_next;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* design/pkt_pkg.sv */
package pkt_pkg;

	typedef enum logic [1:0] {
		kind_udp,
		kind_arp,
		kind_icmp
	} frame_kind_t;

	localparam int frame_bits = 624; // Longest frame, ICMP

	typedef logic [frame_bits-1:0] frame_image_t;
	typedef logic [6:0] frame_len_t;

	typedef struct packed {
		frame_image_t image;
		frame_len_t   len;
	} frame_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} stream_beat_t;

	//////////////////////////////////////////////////////////////////////
	// Frame images, MSB first, zero-padded on the right

	localparam frame_len_t udp_len  = 7'd66;
	localparam frame_len_t arp_len  = 7'd64;
	localparam frame_len_t icmp_len = 7'd78;

	localparam frame_image_t udp_image = {
		48'h00D0_0800_0002, 48'h0024_7EDF_CA5E, 16'h0800,
		16'h4500, 16'h0030, 16'h0012, 16'h4000, 16'h8011, 16'h0000, // IPv4 header
		32'hC0A8_0077, 32'hC0A8_006E,
		16'h1F90, 16'h1F90, 16'h001C, 16'h0000,                     // UDP header
		32'hEEBA_EEBA, 128'h1234_5611_1134_5678_1234_5678_AABB_CCDD,
		32'hCFD9_3530, 96'h0
	};

	localparam frame_image_t arp_image = {
		48'hFFFF_FFFF_FFFF, 48'h0024_7EDF_CA5E, 16'h0806,
		64'h0001_0800_0604_0001,                                    // Request, IPv4 over Ethernet
		48'h0024_7EDF_CA5E, 32'hC0A8_0077, 48'h0, 32'hC0A8_006E,
		144'h0, 32'h59FB_0258, 112'h0
	};

	localparam frame_image_t icmp_image = {
		48'h00D0_0800_0002, 48'h0024_7EDF_CA5E, 16'h0800,
		16'h4500, 16'h003C, 16'h71A0, 16'h0000, 16'h8001, 16'h0000,
		32'hC0A8_0077, 32'hC0A8_006E,
		16'h0800, 16'h4D56, 16'h0001, 16'h0005,                     // Echo request
		256'h6162_6364_6566_6768_696A_6B6C_6D6E_6F70_7172_7374_7576_7761_6263_6465_6667_6869,
		32'hC034_2A1A
	};

endpackage

/* design/traffic_gen_top.sv */
`timescale 1ns/1ps

module traffic_gen_top #(
	parameter int                                frames_per_kind = 5,
	parameter int                                frame_gap       = 16,
	parameter logic [axi_pkg::axi_addr_bits-1:0] base_addr       = 32'h1000_0000,
	parameter logic [axi_pkg::axi_addr_bits-1:0] sum_offset      = 32'h0000_1000,
	parameter int                                burst_len       = 32
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	output logic                  rx_valid,
	output pkt_pkg::stream_beat_t rx_beat,
	input  logic                  rx_ready,
	output logic                  aw_valid,
	output axi_pkg::axi_aw_t      aw,
	input  logic                  aw_ready,
	output logic                  w_valid,
	output axi_pkg::axi_w_t       w,
	input  logic                  w_ready,
	input  logic                  b_valid,
	input  axi_pkg::axi_resp_t    b_resp,
	output logic                  b_ready
);

	logic                load;
	logic                done;
	pkt_pkg::frame_req_t req;

	frame_rotator #(
		.frames_per_kind(frames_per_kind)
	) u_frame_rotator (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.done    (done),
		.load    (load),
		.req     (req)
	);

	byte_streamer #(
		.frame_gap(frame_gap)
	) u_byte_streamer (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.load     (load),
		.req      (req),
		.done     (done),
		.rx_valid (rx_valid),
		.rx_beat  (rx_beat),
		.rx_ready (rx_ready)
	);

	axi_write_master #(
		.base_addr  (base_addr),
		.sum_offset (sum_offset),
		.burst_len  (burst_len)
	) u_axi_write_master (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.aw_valid (aw_valid),
		.aw       (aw),
		.aw_ready (aw_ready),
		.w_valid  (w_valid),
		.w        (w),
		.w_ready  (w_ready),
		.b_valid  (b_valid),
		.b_resp   (b_resp),
		.b_ready  (b_ready)
	);

endmodule

/* tb/tb_traffic_gen_top.sv */
`timescale 1ns/1ps

module tb_traffic_gen_top;

	localparam int          frames_per_kind = 5;
	localparam int          frame_gap       = 16;
	localparam logic [31:0] base_addr       = 32'h1000_0000;
	localparam logic [31:0] sum_offset      = 32'h0000_1000;
	localparam int          burst_len       = 32;
	localparam int          run_limit       = 50000;  // Cycles

	logic                  sys_clk  = 1'b0;
	logic                  sys_rst  = 1'b1;
	logic                  rx_ready = 1'b0;
	logic                  aw_ready = 1'b0;
	logic                  w_ready  = 1'b0;
	logic                  b_valid  = 1'b0;
	axi_pkg::axi_resp_t    b_resp   = 2'b00;
	logic                  rx_valid;
	pkt_pkg::stream_beat_t rx_beat;
	logic                  aw_valid;
	axi_pkg::axi_aw_t      aw;
	logic                  w_valid;
	axi_pkg::axi_w_t       w;
	logic                  b_ready;

	logic [1:0]  b_delay;
	logic        b_pending;
	logic [8:0]  exp_beats[$];  // {data, last}
	logic        in_gap       = 1'b0;
	logic        resp_wait    = 1'b0;
	int          gap_run      = 0;
	int          frames_done  = 0;
	int          frame_errors = 0;
	int          aw_txn       = 0;
	int          w_txn        = 0;
	int          w_idx        = 0;
	int          axi_done     = 0;
	int          axi_errors   = 0;
	int          cycles;
	int unsigned seed_val;

	traffic_gen_top #(
		.frames_per_kind (frames_per_kind),
		.frame_gap       (frame_gap),
		.base_addr       (base_addr),
		.sum_offset      (sum_offset),
		.burst_len       (burst_len)
	) u_dut (.*);

	always #50 sys_clk = ~sys_clk;

	// Returns 1 on mismatch
	function automatic int compare(input string name, input logic [63:0] got, exp);
		int bad;
		bad = 0;
		assert (got === exp) else begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			bad = 1;
		end
		return bad;
	endfunction

	// Appends the bytes of frame number frame_no, rotation UDP, ARP, ICMP
	task automatic queue_frame(input int frame_no);
		pkt_pkg::frame_image_t image;
		int                    len;
		case ((frame_no / frames_per_kind) % 3)
			0: begin
				image = pkt_pkg::udp_image;
				len   = int'(pkt_pkg::udp_len);
			end
			1: begin
				image = pkt_pkg::arp_image;
				len   = int'(pkt_pkg::arp_len);
			end
			default: begin
				image = pkt_pkg::icmp_image;
				len   = int'(pkt_pkg::icmp_len);
			end
		endcase
		for (int i = 0; i < len; i++)
			exp_beats.push_back({image[pkt_pkg::frame_bits-1-8*i -: 8], i == len - 1});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Slave side stimulus

	always @(posedge sys_clk) begin
		rx_ready <= ($urandom % 10) < 7;
		w_ready  <= ($urandom % 10) < 7;
		aw_ready <= 1'($urandom);
	end

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			b_valid   <= 1'b0;
			b_pending <= 1'b0;
			b_delay   <= 2'd0;
		end else if (b_valid && b_ready) begin
			b_valid <= 1'b0;
		end else if (w_valid && w_ready && w.last) begin
			b_pending <= 1'b1;
			b_delay   <= 2'($urandom); // 0 to 3 extra cycles
		end else if (b_pending) begin
			if (b_delay == 2'd0) begin
				b_valid   <= 1'b1;
				b_pending <= 1'b0;
			end else begin
				b_delay <= b_delay - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame stream model

	always @(posedge sys_clk) begin
		logic [8:0] exp;
		if (!sys_rst) begin
			if (in_gap) begin
				if (rx_valid) begin
					assert (gap_run >= frame_gap) else begin
						$display("Gap after frame %0d was only %0d cycles", frames_done, gap_run);
						frame_errors++;
					end
					in_gap = 1'b0;
				end else begin
					gap_run++;
				end
			end
			if (rx_valid && rx_ready) begin
				if (exp_beats.size() == 0)
					queue_frame(frames_done);
				exp = exp_beats.pop_front();
				frame_errors += compare("rx_beat.data", 64'(rx_beat.data), 64'(exp[8:1]));
				frame_errors += compare("rx_beat.last", 64'(rx_beat.last), 64'(exp[0]));
				if (exp[0]) begin
					frames_done++;
					in_gap  = 1'b1;
					gap_run = 0;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// AXI write model, even transactions are marker writes

	always @(posedge sys_clk) begin
		int beats;
		if (!sys_rst) begin
			// B ready only from the last W beat to the response
			axi_errors += compare("b_ready", 64'(b_ready), 64'(resp_wait));
			if (aw_valid && aw_ready) begin
				axi_errors += compare("aw.addr", 64'(aw.addr),
					64'((aw_txn % 2 == 0) ? base_addr : base_addr + sum_offset));
				axi_errors += compare("aw.len", 64'(aw.len),
					64'((aw_txn % 2 == 0) ? 0 : burst_len - 1));
				aw_txn++;
			end
			if (w_valid && w_ready) begin
				beats = (w_txn % 2 == 0) ? 1 : burst_len;
				axi_errors += compare("w.data", w.data,
					(w_txn % 2 == 0) ? axi_pkg::sum_marker : 64'(w_idx));
				axi_errors += compare("w.strb", 64'(w.strb), 64'hFF);
				axi_errors += compare("w.last", 64'(w.last), 64'(w_idx == beats - 1));
				if (w_idx == beats - 1) begin
					w_txn++;
					w_idx     = 0;
					resp_wait = 1'b1;
				end else begin
					w_idx++;
				end
			end
			if (b_valid && b_ready) begin
				axi_done++;
				resp_wait = 1'b0;
			end
		end
	end

	initial begin
		seed_val = $urandom(44240);
		repeat (2) @(posedge sys_clk);
		sys_rst <= 1'b0;
		cycles = 0;
		while (cycles < run_limit && (frames_done < 18 || axi_done < 6)) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (cycles >= run_limit)
			$display("Timeout with %0d frames and %0d AXI writes done", frames_done, axi_done);
		$display("Errors: frame %0d, axi %0d", frame_errors, axi_errors);
		if (frame_errors == 0 && axi_errors == 0 && cycles < run_limit)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* tb/traffic_gen_top_properties.sv */
`timescale 1ns/1ps

module traffic_gen_top_properties (
	input logic                  sys_clk,
	input logic                  sys_rst,
	input logic                  rx_valid,
	input pkt_pkg::stream_beat_t rx_beat,
	input logic                  rx_ready,
	input logic                  aw_valid,
	input axi_pkg::axi_aw_t      aw,
	input logic                  aw_ready,
	input logic                  w_valid,
	input axi_pkg::axi_w_t       w,
	input logic                  w_ready,
	input logic                  b_ready
);

	// Payload holds while stalled
	rx_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_beat))
		else $error("rx_beat changed while stalled");

	aw_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else $error("aw changed while stalled");

	w_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else $error("w changed while stalled");

	quiet_after_reset: assert property (@(posedge sys_clk)
		$fell(sys_rst) |-> !rx_valid && !aw_valid && !w_valid && !b_ready)
		else $error("Valid output high right after reset");

endmodule

bind traffic_gen_top traffic_gen_top_properties u_properties (
	.sys_clk  (sys_clk),
	.sys_rst  (sys_rst),
	.rx_valid (rx_valid),
	.rx_beat  (rx_beat),
	.rx_ready (rx_ready),
	.aw_valid (aw_valid),
	.aw       (aw),
	.aw_ready (aw_ready),
	.w_valid  (w_valid),
	.w        (w),
	.w_ready  (w_ready),
	.b_ready  (b_ready)
);

/* traffic_gen_top.f */
design/pkt_pkg.sv
design/axi_pkg.sv
design/frame_rotator.sv
design/byte_streamer.sv
design/axi_write_master.sv
design/traffic_gen_top.sv
tb/traffic_gen_top_properties.sv
tb/tb_traffic_gen_top.sv
